/* design/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath width
`define MIPS_XLEN 32

// general purpose register file
`define MIPS_REG_COUNT 32
`define MIPS_REG_AW 5

`endif

/* design/mips_pkg.sv */
package mips_pkg;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OP_R_TYPE = 6'b000000,
		OP_ADDI   = 6'b001000,
		OP_ADDIU  = 6'b001001,
		OP_SLTI   = 6'b001010,
		OP_SLTIU  = 6'b001011,
		OP_ANDI   = 6'b001100,
		OP_ORI    = 6'b001101,
		OP_XORI   = 6'b001110,
		OP_LUI    = 6'b001111
	} op_code_e;

	// funct field of SPECIAL words, instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL     = 6'b000000,
		FN_SRL     = 6'b000010,
		FN_SRA     = 6'b000011,
		FN_SLLV    = 6'b000100,
		FN_SRLV    = 6'b000110,
		FN_SRAV    = 6'b000111,
		FN_SYSCALL = 6'b001100,
		FN_BREAK   = 6'b001101,
		FN_ADD     = 6'b100000,
		FN_ADDU    = 6'b100001,
		FN_SUB     = 6'b100010,
		FN_SUBU    = 6'b100011,
		FN_AND     = 6'b100100,
		FN_OR      = 6'b100101,
		FN_XOR     = 6'b100110,
		FN_NOR     = 6'b100111,
		FN_SLT     = 6'b101010,
		FN_SLTU    = 6'b101011
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	typedef enum logic {
		DST_RD = 1'b0, // R-type
		DST_RT = 1'b1  // I-type
	} reg_dst_e;

endpackage

/* design/main_decoder.sv */
`timescale 1ns/1ps

module main_decoder (
	input  logic [31:0]        instr,
	output logic               reg_write_en,
	output mips_pkg::reg_dst_e reg_dst,
	output logic               alu_imm_sel, // operand b from immediate
	output logic               sign_ext,
	output logic               ri,
	output logic               brk,
	output logic               syscall
);

	logic [5:0] op_code;
	logic [5:0] funct;

	assign op_code = instr[31:26];
	assign funct   = instr[5:0];

	always_comb begin
		reg_write_en = 1'b0;
		reg_dst      = mips_pkg::DST_RD;
		alu_imm_sel  = 1'b0;
		sign_ext     = 1'b1;
		ri           = 1'b0;
		brk          = 1'b0;
		syscall      = 1'b0;
		case (op_code)
			mips_pkg::OP_R_TYPE: begin
				case (funct)
					mips_pkg::FN_ADD, mips_pkg::FN_ADDU,
					mips_pkg::FN_SUB, mips_pkg::FN_SUBU,
					mips_pkg::FN_AND, mips_pkg::FN_OR,
					mips_pkg::FN_XOR, mips_pkg::FN_NOR,
					mips_pkg::FN_SLT, mips_pkg::FN_SLTU,
					mips_pkg::FN_SLL, mips_pkg::FN_SRL,
					mips_pkg::FN_SRA, mips_pkg::FN_SLLV,
					mips_pkg::FN_SRLV, mips_pkg::FN_SRAV: begin
						reg_write_en = 1'b1;
					end
					mips_pkg::FN_SYSCALL: syscall = 1'b1;
					mips_pkg::FN_BREAK:   brk = 1'b1;
					default: begin
						ri = 1'b1;
					end
				endcase
			end
			// arithmetic immediates, sign extended
			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU,
			mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU: begin
				reg_write_en = 1'b1;
				reg_dst      = mips_pkg::DST_RT;
				alu_imm_sel  = 1'b1;
			end
			// logic immediates and lui, zero extended
			mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
			mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
				reg_write_en = 1'b1;
				reg_dst      = mips_pkg::DST_RT;
				alu_imm_sel  = 1'b1;
				sign_ext     = 1'b0;
			end
			default: begin
				ri = 1'b1; // loads, stores, branches, cop0 etc
			end
		endcase
	end

endmodule

/* design/alu_decoder.sv */
`timescale 1ns/1ps

module alu_decoder (
	input  logic [31:0]       instr,
	output mips_pkg::alu_op_e alu_op
);

	logic [5:0] op_code;
	logic [5:0] funct;

	assign op_code = instr[31:26];
	assign funct   = instr[5:0];

	always_comb begin
		alu_op = mips_pkg::ALU_ADD;
		case (op_code)
			mips_pkg::OP_R_TYPE: begin
				case (funct)
					mips_pkg::FN_ADD, mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB, mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
					// variable shifts share the op, amount picked in decode
					mips_pkg::FN_SLL, mips_pkg::FN_SLLV: alu_op = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL, mips_pkg::FN_SRLV: alu_op = mips_pkg::ALU_SRL;
					mips_pkg::FN_SRA, mips_pkg::FN_SRAV: alu_op = mips_pkg::ALU_SRA;
					default: begin
						alu_op = mips_pkg::ALU_ADD;
					end
				endcase
			end
			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: alu_op = mips_pkg::ALU_ADD;
			mips_pkg::OP_SLTI:  alu_op = mips_pkg::ALU_SLT;
			mips_pkg::OP_SLTIU: alu_op = mips_pkg::ALU_SLTU;
			mips_pkg::OP_ANDI:  alu_op = mips_pkg::ALU_AND;
			mips_pkg::OP_ORI:   alu_op = mips_pkg::ALU_OR;
			mips_pkg::OP_XORI:  alu_op = mips_pkg::ALU_XOR;
			mips_pkg::OP_LUI:   alu_op = mips_pkg::ALU_LUI;
			default: begin
				alu_op = mips_pkg::ALU_ADD;
			end
		endcase
	end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module register_file (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [`MIPS_REG_AW-1:0] raddr_a,
	input  logic [`MIPS_REG_AW-1:0] raddr_b,
	input  logic                    wen,
	input  logic [`MIPS_REG_AW-1:0] waddr,
	input  logic [`MIPS_XLEN-1:0]   wdata,
	output logic [`MIPS_XLEN-1:0]   rdata_a,
	output logic [`MIPS_XLEN-1:0]   rdata_b
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++) regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 hardwired, then write-through of the pending write
	assign rdata_a = (raddr_a == '0) ? '0 : (wen && waddr == raddr_a) ? wdata : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : (wen && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module decode_stage (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [31:0]             instr,
	input  logic                    instr_valid,
	input  logic [`MIPS_XLEN-1:0]   rdata_a,
	input  logic [`MIPS_XLEN-1:0]   rdata_b,
	output logic [`MIPS_REG_AW-1:0] raddr_a,
	output logic [`MIPS_REG_AW-1:0] raddr_b,
	output logic                    ex_valid,
	output mips_pkg::alu_op_e       ex_alu_op,
	output logic [`MIPS_XLEN-1:0]   ex_operand_a,
	output logic [`MIPS_XLEN-1:0]   ex_operand_b,
	output logic [4:0]              ex_shamt,
	output logic                    ex_wen,
	output logic [`MIPS_REG_AW-1:0] ex_waddr,
	output logic                    ex_ri,
	output logic                    ex_brk,
	output logic                    ex_syscall
);

	logic                    reg_write_en;
	mips_pkg::reg_dst_e      reg_dst;
	logic                    alu_imm_sel;
	logic                    sign_ext;
	logic                    ri;
	logic                    brk;
	logic                    syscall;
	mips_pkg::alu_op_e       alu_op;
	logic [`MIPS_XLEN-1:0]   imm_ext;
	logic [`MIPS_REG_AW-1:0] waddr;
	logic                    wen;

	main_decoder main_decoder_i (
		.instr        (instr),
		.reg_write_en (reg_write_en),
		.reg_dst      (reg_dst),
		.alu_imm_sel  (alu_imm_sel),
		.sign_ext     (sign_ext),
		.ri           (ri),
		.brk          (brk),
		.syscall      (syscall)
	);

	alu_decoder alu_decoder_i (
		.instr  (instr),
		.alu_op (alu_op)
	);

	assign raddr_a = instr[25:21]; // rs
	assign raddr_b = instr[20:16]; // rt

	assign imm_ext = sign_ext ? {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]}
	                          : {{(`MIPS_XLEN-16){1'b0}}, instr[15:0]};

	assign waddr = (reg_dst == mips_pkg::DST_RT) ? instr[20:16] : instr[15:11];
	assign wen   = reg_write_en && (waddr != '0); // r0 writes dropped here

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid   <= 1'b0;
			ex_wen     <= 1'b0;
			ex_ri      <= 1'b0;
			ex_brk     <= 1'b0;
			ex_syscall <= 1'b0;
		end else begin
			ex_valid   <= instr_valid;
			ex_wen     <= instr_valid & wen;
			ex_ri      <= instr_valid & ri;
			ex_brk     <= instr_valid & brk;
			ex_syscall <= instr_valid & syscall;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ex_alu_op    <= alu_op;
			ex_operand_a <= rdata_a;
			ex_operand_b <= alu_imm_sel ? imm_ext : rdata_b;
			ex_shamt     <= instr[2] ? rdata_a[4:0] : instr[10:6]; // funct[2] set for sllv/srlv/srav
			ex_waddr     <= waddr;
		end
	end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module execute_stage (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    ex_valid,
	input  mips_pkg::alu_op_e       ex_alu_op,
	input  logic [`MIPS_XLEN-1:0]   ex_operand_a,
	input  logic [`MIPS_XLEN-1:0]   ex_operand_b,
	input  logic [4:0]              ex_shamt,
	input  logic                    ex_wen,
	input  logic [`MIPS_REG_AW-1:0] ex_waddr,
	input  logic                    ex_ri,
	input  logic                    ex_brk,
	input  logic                    ex_syscall,
	output logic                    wb_en,
	output logic [`MIPS_REG_AW-1:0] wb_addr,
	output logic [`MIPS_XLEN-1:0]   wb_data,
	output logic                    exc_ri,
	output logic                    exc_break,
	output logic                    exc_syscall
);

	logic [`MIPS_XLEN-1:0] alu_result;

	always_comb begin
		case (ex_alu_op)
			mips_pkg::ALU_ADD:  alu_result = ex_operand_a + ex_operand_b; // no overflow trap
			mips_pkg::ALU_SUB:  alu_result = ex_operand_a - ex_operand_b;
			mips_pkg::ALU_AND:  alu_result = ex_operand_a & ex_operand_b;
			mips_pkg::ALU_OR:   alu_result = ex_operand_a | ex_operand_b;
			mips_pkg::ALU_XOR:  alu_result = ex_operand_a ^ ex_operand_b;
			mips_pkg::ALU_NOR:  alu_result = ~(ex_operand_a | ex_operand_b);
			mips_pkg::ALU_SLT:  alu_result = {{(`MIPS_XLEN-1){1'b0}},
			                                  $signed(ex_operand_a) < $signed(ex_operand_b)};
			mips_pkg::ALU_SLTU: alu_result = {{(`MIPS_XLEN-1){1'b0}}, ex_operand_a < ex_operand_b};
			// shifts act on rt
			mips_pkg::ALU_SLL:  alu_result = ex_operand_b << ex_shamt;
			mips_pkg::ALU_SRL:  alu_result = ex_operand_b >> ex_shamt;
			mips_pkg::ALU_SRA:  alu_result = $signed(ex_operand_b) >>> ex_shamt;
			mips_pkg::ALU_LUI:  alu_result = ex_operand_b << 16;
			default:            alu_result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_en       <= 1'b0;
			exc_ri      <= 1'b0;
			exc_break   <= 1'b0;
			exc_syscall <= 1'b0;
		end else begin
			wb_en       <= ex_valid & ex_wen;
			exc_ri      <= ex_valid & ex_ri;
			exc_break   <= ex_valid & ex_brk;
			exc_syscall <= ex_valid & ex_syscall;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			wb_addr <= ex_waddr;
			wb_data <= alu_result;
		end
	end

endmodule

/* design/mips_alu_pipe.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_alu_pipe (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [31:0]             instr,
	input  logic                    instr_valid,
	output logic                    wb_en,
	output logic [`MIPS_REG_AW-1:0] wb_addr,
	output logic [`MIPS_XLEN-1:0]   wb_data,
	output logic                    exc_ri,
	output logic                    exc_break,
	output logic                    exc_syscall
);

	logic [`MIPS_REG_AW-1:0] raddr_a;
	logic [`MIPS_REG_AW-1:0] raddr_b;
	logic [`MIPS_XLEN-1:0]   rdata_a;
	logic [`MIPS_XLEN-1:0]   rdata_b;
	logic                    ex_valid;
	mips_pkg::alu_op_e       ex_alu_op;
	logic [`MIPS_XLEN-1:0]   ex_operand_a;
	logic [`MIPS_XLEN-1:0]   ex_operand_b;
	logic [4:0]              ex_shamt;
	logic                    ex_wen;
	logic [`MIPS_REG_AW-1:0] ex_waddr;
	logic                    ex_ri;
	logic                    ex_brk;
	logic                    ex_syscall;

	decode_stage decode_stage_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.instr        (instr),
		.instr_valid  (instr_valid),
		.rdata_a      (rdata_a),
		.rdata_b      (rdata_b),
		.raddr_a      (raddr_a),
		.raddr_b      (raddr_b),
		.ex_valid     (ex_valid),
		.ex_alu_op    (ex_alu_op),
		.ex_operand_a (ex_operand_a),
		.ex_operand_b (ex_operand_b),
		.ex_shamt     (ex_shamt),
		.ex_wen       (ex_wen),
		.ex_waddr     (ex_waddr),
		.ex_ri        (ex_ri),
		.ex_brk       (ex_brk),
		.ex_syscall   (ex_syscall)
	);

	// write port fed straight from the writeback register
	register_file register_file_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.raddr_a (raddr_a),
		.raddr_b (raddr_b),
		.wen     (wb_en),
		.waddr   (wb_addr),
		.wdata   (wb_data),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	execute_stage execute_stage_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.ex_valid     (ex_valid),
		.ex_alu_op    (ex_alu_op),
		.ex_operand_a (ex_operand_a),
		.ex_operand_b (ex_operand_b),
		.ex_shamt     (ex_shamt),
		.ex_wen       (ex_wen),
		.ex_waddr     (ex_waddr),
		.ex_ri        (ex_ri),
		.ex_brk       (ex_brk),
		.ex_syscall   (ex_syscall),
		.wb_en        (wb_en),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.exc_ri       (exc_ri),
		.exc_break    (exc_break),
		.exc_syscall  (exc_syscall)
	);

endmodule

/* testbench/mips_alu_pipe_chk.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_alu_pipe_chk (
	input logic                    clk,
	input logic                    arst_n,
	input logic                    instr_valid,
	input logic                    wb_en,
	input logic [`MIPS_REG_AW-1:0] wb_addr,
	input logic                    exc_ri,
	input logic                    exc_break,
	input logic                    exc_syscall
);

	int fail_reset = 0;
	int fail_idle  = 0;
	int fail_r0    = 0;
	int fail_multi = 0;
	int fail_count;

	assign fail_count = fail_reset + fail_idle + fail_r0 + fail_multi;

	a_reset_quiet: assert property (@(posedge clk)
		!arst_n |-> !wb_en && !exc_ri && !exc_break && !exc_syscall)
		else begin
			fail_reset++;
			$error("writeback or exception active while in reset");
		end

	// nothing leaves the pipe unless a word was sampled two edges back
	a_idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		!$past(instr_valid, 2) |-> !wb_en && !exc_ri && !exc_break && !exc_syscall)
		else begin
			fail_idle++;
			$error("writeback or exception without a valid instruction two cycles earlier");
		end

	a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
		wb_en |-> wb_addr != '0)
		else begin
			fail_r0++;
			$error("write enable raised for register r0");
		end

	a_one_event: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({wb_en, exc_ri, exc_break, exc_syscall}))
		else begin
			fail_multi++;
			$error("more than one of write enable and exception flags high");
		end

endmodule

bind mips_alu_pipe mips_alu_pipe_chk mips_alu_pipe_chk_i (
	.clk         (clk),
	.arst_n      (arst_n),
	.instr_valid (instr_valid),
	.wb_en       (wb_en),
	.wb_addr     (wb_addr),
	.exc_ri      (exc_ri),
	.exc_break   (exc_break),
	.exc_syscall (exc_syscall)
);

/* testbench/mips_alu_pipe_tb.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_alu_pipe_tb;

	typedef struct packed {
		logic                    wen;
		logic [`MIPS_REG_AW-1:0] addr;
		logic [`MIPS_XLEN-1:0]   data;
		logic                    ri;
		logic                    brk;
		logic                    sys;
	} wb_exp_t;

	// MIPS32 funct and opcode encodings of the supported subset
	localparam logic [5:0] R_FUNCTS [16] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25,
		6'h26, 6'h27, 6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
	localparam logic [5:0] I_OPS [8] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

	logic                    clk;
	logic                    arst_n;
	logic [31:0]             instr;
	logic                    instr_valid;
	logic                    wb_en;
	logic [`MIPS_REG_AW-1:0] wb_addr;
	logic [`MIPS_XLEN-1:0]   wb_data;
	logic                    exc_ri;
	logic                    exc_break;
	logic                    exc_syscall;

	logic [`MIPS_XLEN-1:0]   ref_regs [`MIPS_REG_COUNT];
	wb_exp_t                 exp_q [$];
	logic [31:0]             rnd;
	logic                    busy; // previous instruction writes busy_reg
	logic [`MIPS_REG_AW-1:0] busy_reg;
	int                      errors;
	int                      checks;

	mips_alu_pipe mips_alu_pipe_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.wb_en       (wb_en),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.exc_ri      (exc_ri),
		.exc_break   (exc_break),
		.exc_syscall (exc_syscall)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// architectural result of one word, ok low when outside the subset
	function automatic logic [31:0] alu_model(input logic [31:0] w, input logic [31:0] a,
			input logic [31:0] b, output logic ok);
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [31:0] r;
		simm = {{16{w[15]}}, w[15:0]};
		zimm = {16'h0000, w[15:0]};
		r = '0;
		ok = 1'b1;
		if (w[31:26] == 6'h00) begin
			case (w[5:0])
				6'h20, 6'h21: r = a + b; // add wraps like addu
				6'h22, 6'h23: r = a - b;
				6'h24: r = a & b;
				6'h25: r = a | b;
				6'h26: r = a ^ b;
				6'h27: r = ~(a | b);
				6'h2a: r = {31'd0, $signed(a) < $signed(b)};
				6'h2b: r = {31'd0, a < b};
				6'h00: r = b << w[10:6];
				6'h02: r = b >> w[10:6];
				6'h03: r = $signed(b) >>> w[10:6];
				6'h04: r = b << a[4:0];
				6'h06: r = b >> a[4:0];
				6'h07: r = $signed(b) >>> a[4:0];
				default: ok = 1'b0;
			endcase
		end else begin
			case (w[31:26])
				6'h08, 6'h09: r = a + simm;
				6'h0a: r = {31'd0, $signed(a) < $signed(simm)};
				6'h0b: r = {31'd0, a < simm}; // sign extended, compared unsigned
				6'h0c: r = a & zimm;
				6'h0d: r = a | zimm;
				6'h0e: r = a ^ zimm;
				6'h0f: r = {w[15:0], 16'h0000};
				default: ok = 1'b0;
			endcase
		end
		return r;
	endfunction

	task automatic next_instr(output logic [31:0] w, output logic v);
		logic [31:0]             r1;
		logic [31:0]             r2;
		logic [`MIPS_REG_AW-1:0] rs;
		logic [`MIPS_REG_AW-1:0] rt;
		logic [`MIPS_REG_AW-1:0] rd;
		rnd = xorshift(rnd);
		r1 = rnd;
		rnd = xorshift(rnd);
		r2 = rnd;
		rs = {2'b00, r1[7:5]}; // r0..r7 for dense dependencies
		rt = {2'b00, r1[10:8]};
		rd = {2'b00, r1[13:11]};
		if (busy && rs == busy_reg) rs = rs ^ 5'd1;
		if (busy && rt == busy_reg) rt = rt ^ 5'd1;
		v = 1'b1;
		if (r1[4] == 1'b0) begin
			w = {6'h00, rs, rt, rd, r2[20:16], R_FUNCTS[r1[3:0]]};
		end else if (r1[3] == 1'b0) begin
			w = {I_OPS[r1[2:0]], rs, rt, r2[15:0]};
		end else begin
			case (r1[2:0])
				3'd0: w = {6'h00, r2[25:6], 6'h0d}; // break
				3'd1: w = {6'h00, r2[25:6], 6'h0c}; // syscall
				3'd2: w = {6'h00, rs, rt, 10'h000, 6'h18}; // mult
				3'd3: w = {6'h00, 10'h000, rd, 5'h00, 6'h10}; // mfhi
				3'd4: w = {6'h23, rs, rt, r2[15:0]}; // lw
				3'd5: w = {6'h04, rs, rt, r2[15:0]}; // beq
				default: begin
					w = r2; // idle, junk on the bus
					v = 1'b0;
				end
			endcase
		end
	endtask

	task automatic predict_outcome(input logic [31:0] w, input logic v, output wb_exp_t e);
		logic                    ok;
		logic [`MIPS_REG_AW-1:0] dst;
		e = '0;
		busy = 1'b0;
		if (v) begin
			dst = (w[31:26] == 6'h00) ? w[15:11] : w[20:16];
			e.data = alu_model(w, ref_regs[w[25:21]], ref_regs[w[20:16]], ok);
			if (w[31:26] == 6'h00 && w[5:0] == 6'h0d) begin
				e.brk = 1'b1;
			end else if (w[31:26] == 6'h00 && w[5:0] == 6'h0c) begin
				e.sys = 1'b1;
			end else if (!ok) begin
				e.ri = 1'b1;
			end else if (dst != '0) begin
				e.wen = 1'b1;
				e.addr = dst;
				ref_regs[dst] = e.data;
				busy = 1'b1;
				busy_reg = dst;
			end
		end
	endtask

	task automatic check_outputs(input wb_exp_t e);
		checks++;
		assert (wb_en === e.wen) else begin
			errors++;
			$display("ERROR %0t wb_en expected %0b got %0b", $time, e.wen, wb_en);
		end
		assert (exc_ri === e.ri) else begin
			errors++;
			$display("ERROR %0t exc_ri expected %0b got %0b", $time, e.ri, exc_ri);
		end
		assert (exc_break === e.brk) else begin
			errors++;
			$display("ERROR %0t exc_break expected %0b got %0b", $time, e.brk, exc_break);
		end
		assert (exc_syscall === e.sys) else begin
			errors++;
			$display("ERROR %0t exc_syscall expected %0b got %0b", $time, e.sys, exc_syscall);
		end
		if (e.wen) begin
			assert (wb_addr === e.addr) else begin
				errors++;
				$display("ERROR %0t wb_addr expected %0d got %0d", $time, e.addr, wb_addr);
			end
			assert (wb_data === e.data) else begin
				errors++;
				$display("ERROR %0t wb_data expected %h got %h", $time, e.data, wb_data);
			end
		end
	endtask

	initial begin
		logic [31:0] word;
		logic        valid;
		wb_exp_t     e;
		int          guard;
		arst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		rnd = 32'h7c52;
		busy = 1'b0;
		busy_reg = '0;
		errors = 0;
		checks = 0;
		for (int i = 0; i < `MIPS_REG_COUNT; i++) ref_regs[i] = '0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		// each word is checked two edges after it is sampled
		for (int n = 0; n < 600; n++) begin
			@(posedge clk);
			next_instr(word, valid);
			instr <= word;
			instr_valid <= valid;
			predict_outcome(word, valid, e);
			exp_q.push_back(e);
			@(negedge clk);
			if (exp_q.size() > 2) begin
				e = exp_q.pop_front();
				check_outputs(e);
			end
		end

		guard = 0;
		while (exp_q.size() > 0 && guard < 10) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			@(negedge clk);
			e = exp_q.pop_front();
			check_outputs(e);
			guard++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("timeout: pipeline results still pending after the drain cycles");
		end

		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			mips_alu_pipe_i.mips_alu_pipe_chk_i.fail_count);
		if (errors == 0 && mips_alu_pipe_i.mips_alu_pipe_chk_i.fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* mips_alu_pipe.f */
+incdir+design
design/mips_pkg.sv
design/main_decoder.sv
design/alu_decoder.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mips_alu_pipe.sv
testbench/mips_alu_pipe_chk.sv
testbench/mips_alu_pipe_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mips_alu_pipe_tb \
	-f mips_alu_pipe.f -o sim_mips_alu_pipe
./obj_dir/sim_mips_alu_pipe +verilator+error+limit+1000 | tee sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
grep -q "Testbench passed" sim.log
